// ==== Makefile ====
# Verilator build for the cpu testbench.

VERILATOR  ?= verilator
TOP        ?= tb_cpu
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) cpu_params.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# a $$fatal in the testbench gives a non-zero exit status.
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_core_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_sequencer.sv
cpu_top.sv
tb_cpu.sv

// ==== cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
	input  cpu_isa_pkg::alu_op_t op,
	input  cpu_core_pkg::byte_t  a,
	input  cpu_core_pkg::byte_t  arg,
	input  cpu_core_pkg::byte_t  inc_arg,
	input  logic                 dec,
	input  cpu_core_pkg::flags_t flags,
	output cpu_core_pkg::byte_t  result,
	output cpu_core_pkg::flags_t new_flags
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	logic       cin;
	logic [8:0] sum; // bit 8 is the carry.
	logic [8:0] diff; // bit 8 is the borrow.
	byte_t      step;
	flags_t     rule; // flag values from the op rules.
	flags_t     upd; // which flags take the rule value.

	// ******************************
	// arithmetic.
	// ******************************
	assign cin  = ((op == ALU_ADC) || (op == ALU_SBC)) && flags.c; // only adc/sbc chain c.
	assign sum  = {1'b0, a} + {1'b0, arg} + {8'd0, cin};
	assign diff = {1'b0, a} - {1'b0, arg} - {8'd0, cin};
	assign step = dec ? (inc_arg - 1'b1) : (inc_arg + 1'b1);

	// ******************************
	// result and flag rules.
	// ******************************
	always_comb
	begin
		rule   = '0;
		upd    = '1; // all four flags unless the op says otherwise.
		result = a;
		case (op)
		ALU_ADD, ALU_ADC:
			begin
				result = sum[7:0];
				rule.h = a[4] ^ arg[4] ^ sum[4]; // carry into bit 4.
				rule.c = sum[8];
			end
		ALU_SUB, ALU_SBC, ALU_CP:
			begin
				result = diff[7:0];
				rule.n = 1'b1;
				rule.h = a[4] ^ arg[4] ^ diff[4]; // borrow from bit 4.
				rule.c = diff[8];
			end
		ALU_AND:
			begin
				result = a & arg;
				rule.h = 1'b1;
			end
		ALU_XOR: result = a ^ arg;
		ALU_OR:  result = a | arg;
		ALU_INCDEC:
			begin
				result = step;
				rule.n = dec;
				rule.h = inc_arg[4] ^ step[4]; // same carry rule with a 1 operand.
				upd.c  = 1'b0; // inc/dec keep c.
			end
		default: upd = '0; // unused codes leave the flags alone.
		endcase
		rule.z = (result == '0);
	end

	// merge rule flags over the current ones.
	assign new_flags = flags_t'((rule & upd) | (flags & ~upd));

endmodule

// ==== cpu_core_pkg.sv ====
`include "cpu_params.svh"

package cpu_core_pkg;

	// ******************************
	// datapath widths.
	// ******************************

	typedef logic [`CPU_DATA_W-1:0] byte_t; // one bus byte.
	typedef logic [`CPU_ADDR_W-1:0] addr_t; // one bus address.
	typedef logic [$clog2(`CPU_MCYCLE_CLKS)-1:0] mcycle_t; // clock index in a machine cycle.

	// flag register, upper nibble of f.
	typedef struct packed {
		logic z; // zero.
		logic n; // last op was a subtract.
		logic h; // half carry.
		logic c; // carry.
	} flags_t;

	// ******************************
	// bus and sequencer.
	// ******************************

	// single master bus, no wait states.
	typedef struct packed {
		addr_t adr;
		logic  read; // high in clocks 2 and 3 of a fetch.
	} bus_req_t;

	typedef enum logic [1:0] {
		ST_IFETCH     = 2'd0, // opcode fetch.
		ST_IMML_FETCH = 2'd1, // first operand byte.
		ST_IMMH_FETCH = 2'd2, // second operand byte, jp only.
		ST_JUMP       = 2'd3  // idle cycle that loads pc.
	} seq_state_t;

	// register file write port.
	typedef struct packed {
		logic                  we;
		cpu_isa_pkg::reg_sel_t sel; // never REG_IMM.
		byte_t                 val;
	} reg_wr_t;

endpackage

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// ******************************
	// opcode fields.
	// ******************************

	// register field, bits [5:3] pick the target and bits [2:0] the source.
	// code 6 stands for the immediate byte.
	typedef enum logic [2:0] {
		REG_B   = 3'd0,
		REG_C   = 3'd1,
		REG_D   = 3'd2,
		REG_E   = 3'd3,
		REG_H   = 3'd4,
		REG_L   = 3'd5,
		REG_IMM = 3'd6, // operand comes from the imml latch.
		REG_A   = 3'd7
	} reg_sel_t;

	// alu field, bits [5:3] of the 0x80..0xbf block and of the d8 forms.
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0, // a + arg.
		ALU_ADC    = 4'd1, // a + arg + c.
		ALU_SUB    = 4'd2, // a - arg.
		ALU_SBC    = 4'd3, // a - arg - c.
		ALU_AND    = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_OR     = 4'd6,
		ALU_CP     = 4'd7, // subtract for flags only.
		ALU_INCDEC = 4'd8  // single register step, never seen in the opcode field.
	} alu_op_t;

	// condition field, bits [4:3] of jp cc and jr cc.
	typedef enum logic [1:0] {
		COND_NZ = 2'd0,
		COND_Z  = 2'd1,
		COND_NC = 2'd2,
		COND_C  = 2'd3
	} cond_t;

endpackage

// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ******************************
// bus geometry.
// ******************************

`define CPU_DATA_W 8 // data bus width.
`define CPU_ADDR_W 16 // address bus width.

// ******************************
// machine cycle timing.
// ******************************

`define CPU_MCYCLE_CLKS 4 // clocks per bus access.
`define CPU_RESET_PC 0 // first opcode fetch address.

`endif

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
	input  logic                  clk,
	input  cpu_isa_pkg::reg_sel_t src_sel,
	input  cpu_isa_pkg::reg_sel_t dst_sel,
	input  cpu_core_pkg::reg_wr_t reg_wr,
	input  logic                  flags_we,
	input  cpu_core_pkg::flags_t  new_flags,
	output cpu_core_pkg::byte_t   src,
	output cpu_core_pkg::byte_t   dst,
	output cpu_core_pkg::byte_t   a,
	output cpu_core_pkg::flags_t  flags
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	localparam logic [2:0] A_SLOT = 3'd6; // a sits in slot 6.

	byte_t  regs [7]; // b, c, d, e, h, l, a.
	flags_t f_q;

	// opcode field to storage slot.
	function automatic logic [2:0] slot(input reg_sel_t sel);
		return (sel == REG_A) ? A_SLOT : sel;
	endfunction

	// the immediate code reads as zero, the sequencer swaps in imml.
	function automatic byte_t rd(input reg_sel_t sel);
		return (sel == REG_IMM) ? '0 : regs[slot(sel)];
	endfunction

	always_comb
	begin
		src = rd(src_sel); // ld source and alu operand.
		dst = rd(dst_sel); // inc/dec operand.
	end

	assign a     = regs[A_SLOT];
	assign flags = f_q;

	always_ff @(posedge clk)
	begin
		if (reg_wr.we)
			regs[slot(reg_wr.sel)] <= reg_wr.val;
		if (flags_we)
			f_q <= new_flags;
	end

	// decode only ever retires into a real register.
	assert property (@(posedge clk) reg_wr.we |-> (reg_wr.sel != REG_IMM));

endmodule

// ==== cpu_sequencer.sv ====
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_sequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_core_pkg::byte_t   din,
	output cpu_core_pkg::bus_req_t bus,
	output cpu_core_pkg::addr_t   pc,
	output cpu_isa_pkg::reg_sel_t src_sel,
	output cpu_isa_pkg::reg_sel_t dst_sel,
	input  cpu_core_pkg::byte_t   src,
	input  cpu_core_pkg::byte_t   dst,
	input  cpu_core_pkg::byte_t   a,
	input  cpu_core_pkg::flags_t  flags,
	output cpu_isa_pkg::alu_op_t  alu_op,
	output cpu_core_pkg::byte_t   alu_arg,
	output cpu_core_pkg::byte_t   alu_inc_arg,
	input  cpu_core_pkg::byte_t   result,
	input  cpu_core_pkg::flags_t  new_flags,
	output cpu_core_pkg::reg_wr_t reg_wr,
	output logic                  flags_we
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	// clocks inside one machine cycle.
	localparam mcycle_t CYC_ADR   = mcycle_t'(0); // address goes out.
	localparam mcycle_t CYC_RD    = mcycle_t'(1); // read rises, pc steps.
	localparam mcycle_t CYC_LATCH = mcycle_t'(2); // din sampled.
	localparam mcycle_t CYC_LAST  = mcycle_t'(`CPU_MCYCLE_CLKS - 1); // read falls, retire.

	mcycle_t    cycle;
	seq_state_t state;
	seq_state_t next_state;
	addr_t      adr_q;
	logic       read_q;
	byte_t      op; // current opcode.
	byte_t      imml; // d8, e8 or low a16 byte.
	byte_t      immh; // high a16 byte.
	byte_t      operand;
	addr_t      add16_b;
	addr_t      add16; // pc incrementer and jr adder.
	addr_t      pc_target;
	logic       last;
	logic       fetching;
	logic       cond_true;
	logic       taken;
	logic       is_ld_rr, is_ld_imm, is_alu_reg, is_alu_imm;
	logic       is_incdec, is_jp, is_jr;
	logic       ld_done, alu_done, incdec_done;

	assign last     = (cycle == CYC_LAST);
	assign fetching = (state != ST_JUMP); // every state but jump reads a byte.
	assign bus      = '{adr: adr_q, read: read_q};

	// ******************************
	// decode.
	// ******************************
	assign src_sel = reg_sel_t'(op[2:0]);
	assign dst_sel = reg_sel_t'(op[5:3]);

	assign is_ld_rr   = (op[7:6] == 2'b01) && (dst_sel != REG_IMM) && (src_sel != REG_IMM);
	assign is_ld_imm  = (op[7:6] == 2'b00) && (src_sel == REG_IMM) && (dst_sel != REG_IMM);
	assign is_alu_reg = (op[7:6] == 2'b10) && (src_sel != REG_IMM);
	assign is_alu_imm = (op[7:6] == 2'b11) && (src_sel == REG_IMM);
	assign is_incdec  = (op[7:6] == 2'b00) && (op[2:1] == 2'b10) && (dst_sel != REG_IMM);
	assign is_jp      = (op == 8'hc3) || ((op[7:5] == 3'b110) && (op[2:0] == 3'b010));
	assign is_jr      = (op == 8'h18) || ((op[7:5] == 3'b001) && (op[2:0] == 3'b000));

	always_comb
	begin
		case (cond_t'(op[4:3]))
		COND_NZ: cond_true = !flags.z;
		COND_Z:  cond_true = flags.z;
		COND_NC: cond_true = !flags.c;
		default: cond_true = flags.c;
		endcase
	end
	assign taken = (op == 8'hc3) || (op == 8'h18) || cond_true; // plain jp and jr always go.

	// alu feed.
	assign operand     = (src_sel == REG_IMM) ? imml : src;
	assign alu_arg     = operand;
	assign alu_inc_arg = dst;
	assign alu_op      = is_incdec ? ALU_INCDEC : alu_op_t'({1'b0, op[5:3]});

	// +1 while fetching, +e8 in the jump state.
	assign add16_b   = (state == ST_JUMP) ? addr_t'($signed(imml)) : addr_t'(1);
	assign add16     = pc + add16_b;
	assign pc_target = is_jr ? add16 : {immh, imml};

	always_comb
	begin
		next_state = ST_IFETCH; // one machine cycle unless an operand follows.
		case (state)
		ST_IFETCH:
			if (is_ld_imm || is_alu_imm || is_jp || is_jr)
				next_state = ST_IMML_FETCH;
		ST_IMML_FETCH:
			if (is_jp)
				next_state = ST_IMMH_FETCH;
			else if (is_jr && taken)
				next_state = ST_JUMP;
		ST_IMMH_FETCH:
			if (taken)
				next_state = ST_JUMP;
		default:
			next_state = ST_IFETCH;
		endcase
	end

	// ******************************
	// write-back.
	// ******************************
	assign ld_done     = ((state == ST_IFETCH) && is_ld_rr)
		|| ((state == ST_IMML_FETCH) && is_ld_imm);
	assign alu_done    = ((state == ST_IFETCH) && is_alu_reg)
		|| ((state == ST_IMML_FETCH) && is_alu_imm);
	assign incdec_done = (state == ST_IFETCH) && is_incdec;

	always_comb
	begin
		reg_wr.we  = last && (ld_done || incdec_done || (alu_done && (alu_op != ALU_CP)));
		reg_wr.sel = alu_done ? REG_A : dst_sel; // alu results land in a.
		reg_wr.val = ld_done ? operand : result;
	end
	assign flags_we = last && (alu_done || incdec_done);

	// ******************************
	// registers.
	// ******************************
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cycle  <= CYC_ADR;
			state  <= ST_IFETCH;
			read_q <= 1'b0;
			pc     <= addr_t'(`CPU_RESET_PC);
		end
		else
		begin
			cycle <= last ? CYC_ADR : mcycle_t'(cycle + 1'b1);
			if (fetching && (cycle == CYC_RD))
			begin
				read_q <= 1'b1;
				pc     <= add16; // pc points past the byte being read.
			end
			if (last)
			begin
				read_q <= 1'b0;
				state  <= next_state;
				if (state == ST_JUMP)
					pc <= pc_target;
			end
		end
	end

	// bus address and fetched bytes.
	always_ff @(posedge clk)
	begin
		if (fetching && (cycle == CYC_ADR))
			adr_q <= pc;
		if (cycle == CYC_LATCH)
		begin
			case (state)
			ST_IFETCH:     op   <= din;
			ST_IMML_FETCH: imml <= din;
			ST_IMMH_FETCH: immh <= din;
			default:       ;
			endcase
		end
	end

	// read never leaks into the address or increment clocks.
	assert property (@(posedge clk) disable iff (reset)
		read_q |-> ((cycle == CYC_LATCH) || (cycle == CYC_LAST)));

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
	input  logic                   clk,
	input  logic                   reset,
	input  cpu_core_pkg::byte_t    din,
	output cpu_core_pkg::bus_req_t bus,
	output cpu_core_pkg::addr_t    pc,
	output cpu_core_pkg::byte_t    a,
	output cpu_core_pkg::flags_t   f
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	reg_sel_t src_sel;
	reg_sel_t dst_sel;
	byte_t    src;
	byte_t    dst;
	alu_op_t  alu_op;
	byte_t    alu_arg;
	byte_t    alu_inc_arg;
	byte_t    result;
	flags_t   new_flags;
	reg_wr_t  reg_wr;
	logic     flags_we;

	// ******************************
	// control.
	// ******************************
	cpu_sequencer sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.din         (din),
		.bus         (bus),
		.pc          (pc),
		.src_sel     (src_sel),
		.dst_sel     (dst_sel),
		.src         (src),
		.dst         (dst),
		.a           (a),
		.flags       (f),
		.alu_op      (alu_op),
		.alu_arg     (alu_arg),
		.alu_inc_arg (alu_inc_arg),
		.result      (result),
		.new_flags   (new_flags),
		.reg_wr      (reg_wr),
		.flags_we    (flags_we)
	);

	// ******************************
	// datapath.
	// ******************************
	cpu_regfile regfile_i (
		.clk       (clk),
		.src_sel   (src_sel),
		.dst_sel   (dst_sel),
		.reg_wr    (reg_wr),
		.flags_we  (flags_we),
		.new_flags (new_flags),
		.src       (src),
		.dst       (dst),
		.a         (a),
		.flags     (f)
	);

	// opcode bit 0 is src_sel bit 0, so it splits inc (x4/xc) from dec (x5/xd).
	cpu_alu alu_i (
		.op        (alu_op),
		.a         (a),
		.arg       (alu_arg),
		.inc_arg   (alu_inc_arg),
		.dec       (src_sel[0]),
		.flags     (f),
		.result    (result),
		.new_flags (new_flags)
	);

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
	import cpu_core_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int SEED         = 39;
	localparam int ROM_SIZE     = 256;
	localparam int N_PREFIX     = 8; // ld a, xor a, six register loads.
	localparam int N_RANDOM     = 60;
	localparam int N_INSTR      = N_PREFIX + N_RANDOM;
	localparam int WATCHDOG_NS  = N_INSTR * 16 * CLK_PERIOD + 20000; // worst case 16 clocks each.

	// opcodes outside the kept set, each runs as a 4 clock nop.
	localparam logic [7:0] DROPPED [12] = '{8'h27, 8'h2f, 8'h37, 8'h3f, 8'hf3, 8'hfb,
		8'hc9, 8'hc5, 8'h76, 8'h86, 8'h34, 8'hcb};

	// architectural state of the reference model.
	typedef struct packed {
		logic [7:0][7:0] regs; // by register code, slot 6 unused.
		logic [3:0]      flags; // z n h c.
		logic [15:0]     pc;
		logic [4:0]      clocks; // length of the last instruction.
		logic [1:0]      fetches; // bytes it read.
	} model_t;

	logic       clk;
	logic       reset;
	logic [7:0] din;
	bus_req_t   bus;
	logic [15:0] pc;
	logic [7:0] a;
	logic [3:0] f;

	logic [7:0]  rom [ROM_SIZE];
	int          instr_addr [$]; // start of each instruction, then the end address.
	int          jump_kind [$]; // 0 none, 1 jp, 2 jr.
	logic [15:0] end_pc;

	cpu_top cpu_top_i (
		.clk   (clk),
		.reset (reset),
		.din   (din),
		.bus   (bus),
		.pc    (pc),
		.a     (a),
		.f     (f)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// rom answers on the falling edge while read is high.
	always @(negedge clk)
		if (bus.read === 1'b1)
			din = rom[bus.adr[7:0]];

	// ******************************
	// reference model.
	// ******************************
	function automatic logic [11:0] alu_model(input logic [2:0] kind, input logic [7:0] x,
		input logic [7:0] y, input logic [3:0] fl);
		int cin;
		int r;
		logic [7:0] res;
		logic z, n, h, c;
		cin = ((kind == 3'd1 || kind == 3'd3) && fl[0]) ? 1 : 0; // adc and sbc only.
		n = 1'b0;
		h = 1'b0;
		c = 1'b0;
		res = x;
		case (kind)
		3'd0, 3'd1:
			begin
				r = int'(x) + int'(y) + cin;
				res = 8'(r);
				h = ((int'(x) % 16) + (int'(y) % 16) + cin) > 15; // carry out of bit 3.
				c = r > 255;
			end
		3'd2, 3'd3, 3'd7:
			begin
				r = int'(x) - int'(y) - cin;
				res = 8'(r);
				n = 1'b1;
				h = (int'(x) % 16) < ((int'(y) % 16) + cin); // borrow from bit 4.
				c = r < 0;
			end
		3'd4:
			begin
				res = x & y;
				h = 1'b1;
			end
		3'd5: res = x ^ y;
		default: res = x | y;
		endcase
		z = (res == 8'd0);
		if (kind == 3'd7)
			res = x; // cp keeps a.
		return {res, z, n, h, c};
	endfunction

	function automatic logic cond_met(input logic [1:0] cc, input logic [3:0] fl);
		case (cc)
		2'd0: return !fl[3]; // nz.
		2'd1: return fl[3];
		2'd2: return !fl[0]; // nc.
		default: return fl[0];
		endcase
	endfunction

	// one instruction, b1 and b2 are the bytes after the opcode.
	function automatic model_t execute(input model_t s, input logic [7:0] op,
		input logic [7:0] b1, input logic [7:0] b2);
		model_t n;
		logic [2:0] dst;
		logic [2:0] src;
		logic [11:0] alu;
		logic [7:0] v;
		n = s;
		dst = op[5:3];
		src = op[2:0];
		n.pc = s.pc + 16'd1;
		n.clocks = 5'd4; // unknown opcodes end up here too.
		n.fetches = 2'd1;
		casez (op)
		8'b01??????:
			if (dst != 3'd6 && src != 3'd6)
				n.regs[dst] = s.regs[src];
		8'b00???110:
			if (dst != 3'd6)
			begin
				n.regs[dst] = b1;
				n.pc = s.pc + 16'd2;
				n.clocks = 5'd8;
				n.fetches = 2'd2;
			end
		8'b10??????:
			if (src != 3'd6)
			begin
				alu = alu_model(dst, s.regs[7], s.regs[src], s.flags);
				n.regs[7] = alu[11:4];
				n.flags = alu[3:0];
			end
		8'b11???110:
			begin
				alu = alu_model(dst, s.regs[7], b1, s.flags);
				n.regs[7] = alu[11:4];
				n.flags = alu[3:0];
				n.pc = s.pc + 16'd2;
				n.clocks = 5'd8;
				n.fetches = 2'd2;
			end
		8'b00???10?:
			if (dst != 3'd6)
			begin
				v = s.regs[dst];
				n.regs[dst] = op[0] ? v - 8'd1 : v + 8'd1;
				n.flags[3] = (n.regs[dst] == 8'd0);
				n.flags[2] = op[0]; // dec sets n.
				n.flags[1] = op[0] ? (v[3:0] == 4'h0) : (v[3:0] == 4'hf);
			end
		8'hc3, 8'b110??010:
			begin
				n.pc = s.pc + 16'd3;
				n.clocks = 5'd12;
				n.fetches = 2'd3;
				if (op == 8'hc3 || cond_met(op[4:3], s.flags))
				begin
					n.pc = {b2, b1};
					n.clocks = 5'd16;
				end
			end
		8'h18, 8'b001??000:
			begin
				n.pc = s.pc + 16'd2;
				n.clocks = 5'd8;
				n.fetches = 2'd2;
				if (op == 8'h18 || cond_met(op[4:3], s.flags))
				begin
					n.pc = s.pc + 16'd2 + {{8{b1[7]}}, b1}; // relative to the next opcode.
					n.clocks = 5'd12;
				end
			end
		default: ;
		endcase
		return n;
	endfunction

	// ******************************
	// program and checks.
	// ******************************
	function automatic logic [2:0] pick_reg();
		logic [2:0] r;
		r = 3'($urandom_range(0, 6));
		return (r == 3'd6) ? 3'd7 : r; // code 6 is the immediate.
	endfunction

	task automatic build_program();
		logic [7:0] p;
		logic [7:0] t;
		logic [7:0] at;
		logic [2:0] cc;
		int kind;
		int len;
		int jk;
		int j;
		for (int i = 0; i < ROM_SIZE; i++)
			rom[8'(i)] = 8'(i * 29 + 7); // filler past the program.
		rom[8'd0] = 8'h3e; // ld a,d8 first so xor a sees a known a.
		rom[8'd1] = 8'($urandom);
		rom[8'd2] = 8'haf; // xor a, every flag known.
		instr_addr.push_back(0);
		instr_addr.push_back(2);
		jump_kind.push_back(0);
		jump_kind.push_back(0);
		p = 8'd3;
		for (int r = 0; r < 6; r++)
		begin
			instr_addr.push_back(int'(p));
			jump_kind.push_back(0);
			rom[p] = {2'b00, 3'(r), 3'd6}; // ld b..l,d8.
			rom[p + 8'd1] = 8'($urandom);
			p += 8'd2;
		end
		for (int i = 0; i < N_RANDOM; i++)
		begin
			instr_addr.push_back(int'(p));
			kind = int'($urandom_range(0, 8));
			len = 1;
			jk = 0;
			cc = 3'($urandom_range(0, 4)); // 4 picks the plain jump.
			case (kind)
			0: rom[p] = {2'b01, pick_reg(), pick_reg()};
			1:
				begin
					rom[p] = {2'b00, pick_reg(), 3'd6};
					len = 2;
				end
			2, 3: rom[p] = {2'b10, 3'($urandom_range(0, 7)), pick_reg()};
			4:
				begin
					rom[p] = {2'b11, 3'($urandom_range(0, 7)), 3'd6};
					len = 2;
				end
			5: rom[p] = {2'b00, pick_reg(), 2'b10, 1'($urandom_range(0, 1))};
			6:
				begin
					rom[p] = (cc == 3'd4) ? 8'hc3 : {3'b110, cc[1:0], 3'b010};
					len = 3;
					jk = 1;
				end
			7:
				begin
					rom[p] = (cc == 3'd4) ? 8'h18 : {3'b001, cc[1:0], 3'b000};
					len = 2;
					jk = 2;
				end
			default: rom[p] = DROPPED[4'($urandom_range(0, 11))];
			endcase
			jump_kind.push_back(jk);
			if (len > 1)
				rom[p + 8'd1] = 8'($urandom); // immediate, or patched below.
			p += 8'(len);
		end
		instr_addr.push_back(int'(p));
		end_pc = 16'(p);
		// targets lie one to four instructions ahead, at most the end.
		for (int i = 0; i < N_INSTR; i++)
			if (jump_kind[i] != 0)
			begin
				j = i + int'($urandom_range(1, 4));
				if (j > N_INSTR)
					j = N_INSTR;
				t = 8'(instr_addr[j]);
				at = 8'(instr_addr[i]);
				if (jump_kind[i] == 1)
				begin
					rom[at + 8'd1] = t;
					rom[at + 8'd2] = 8'h00;
				end
				else
					rom[at + 8'd1] = t - (at + 8'd2);
			end
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// counts falling edges up to the next rise of read.
	task automatic wait_read_rise(output int clocks);
		logic seen_low;
		clocks = 0;
		seen_low = 1'b0;
		do
		begin
			@(negedge clk);
			clocks++;
			if (bus.read !== 1'b1)
				seen_low = 1'b1;
		end
		while (!(seen_low && (bus.read === 1'b1)));
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the program did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		model_t m;
		model_t nm;
		int gap;
		int clocks;
		int count;
		logic done;
		clk = 1'b0;
		reset = 1'b1;
		din = 8'h00;
		void'($urandom(SEED)); // the only seed of the run.
		build_program();
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			check_value("bus.read", 16'(bus.read), 16'h0000); // quiet bus in reset.
		end
		reset = 1'b0;
		wait_read_rise(gap);
		check_value("first fetch clocks", 16'(gap), 16'd2);
		m = '0;
		m.regs = 'x;
		m.flags = 'x;
		count = 0;
		done = 1'b0;
		while (!done)
		begin
			// opcode fetch, state of the previous instruction is visible.
			check_value("bus.adr", bus.adr, m.pc);
			check_value("pc", pc, m.pc + 16'd1); // pc steps as read rises.
			if (count >= 1)
				check_value("a", 16'(a), 16'(m.regs[7]));
			if (count >= 2)
				check_value("f", 16'(f), 16'(m.flags));
			if (m.pc == end_pc)
				done = 1'b1;
			else
			begin
				nm = execute(m, rom[8'(m.pc)], rom[8'(m.pc + 16'd1)], rom[8'(m.pc + 16'd2)]);
				clocks = 0;
				for (int k = 1; k < int'(nm.fetches); k++)
				begin
					wait_read_rise(gap);
					clocks += gap;
					check_value("bus.adr", bus.adr, m.pc + 16'(k)); // operand bytes.
					check_value("pc", pc, m.pc + 16'(k + 1));
				end
				wait_read_rise(gap);
				clocks += gap;
				check_value("fetch clocks", 16'(clocks), 16'(nm.clocks));
				m = nm;
				count++;
			end
		end
		$display("TEST PASS");
		$finish;
	end

endmodule
